// ==== design/core_pkg.sv ====
package core_pkg;

   localparam int XLEN      = 32;
   localparam int ROB_WIDTH = 5;   // rob index bits, robid adds a wrap bit
   localparam int PRF_WIDTH = 6;

   typedef logic [XLEN-1:0]      word_t;
   typedef logic [ROB_WIDTH:0]   robid_t;  // msb is the wrap bit
   typedef logic [PRF_WIDTH-1:0] prd_t;

   // true when robid a was allocated after robid b
   function automatic logic rob_younger(input robid_t a, input robid_t b);
      logic same_wrap;
      logic a_above;
      same_wrap = (a[ROB_WIDTH] == b[ROB_WIDTH]);
      a_above   = (a[ROB_WIDTH-1:0] > b[ROB_WIDTH-1:0]);
      if (same_wrap) begin
         return a_above;
      end
      // wrapped once, smaller index came later
      return (a[ROB_WIDTH-1:0] < b[ROB_WIDTH-1:0]);
   endfunction

endpackage

// ==== design/exec_pkg.sv ====
package exec_pkg;

   localparam int MUL_LATENCY = 3;   // issue to writeback0, in cycles
   localparam int HALF_WIDTH  = 16;  // multiplier split width
   localparam int SHAMT_WIDTH = 5;

   typedef logic [HALF_WIDTH-1:0]  half_t;
   typedef logic [SHAMT_WIDTH-1:0] shamt_t;

   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_SLL    = 4'd2,
      ALU_SLT    = 4'd3,
      ALU_SLTU   = 4'd4,
      ALU_XOR    = 4'd5,
      ALU_SRL    = 4'd6,
      ALU_SRA    = 4'd7,
      ALU_OR     = 4'd8,
      ALU_AND    = 4'd9,
      ALU_PASS_B = 4'd10   // lui
   } alu_op_t;

endpackage

// ==== design/alu.sv ====
module alu
   import core_pkg::*, exec_pkg::*;
(
   input  alu_op_t alu_op,
   input  word_t   left_operand,
   input  word_t   right_operand,
   output word_t   result
);

   shamt_t shamt;
   logic   lt_signed;
   logic   lt_unsigned;

   // only the low bits count for shifts
   assign shamt = right_operand[SHAMT_WIDTH-1:0];

   assign lt_signed   = ($signed(left_operand) < $signed(right_operand));
   assign lt_unsigned = (left_operand < right_operand);

   always_comb begin
      case (alu_op)
         ALU_ADD: begin
            result = left_operand + right_operand;  // also auipc
         end
         ALU_SUB: begin
            result = left_operand - right_operand;
         end
         ALU_SLL: begin
            result = left_operand << shamt;
         end
         ALU_SLT: begin
            result = word_t'(lt_signed);
         end
         ALU_SLTU: begin
            result = word_t'(lt_unsigned);
         end
         ALU_XOR: begin
            result = left_operand ^ right_operand;
         end
         ALU_SRL: begin
            result = left_operand >> shamt;
         end
         ALU_SRA: begin
            result = word_t'($signed(left_operand) >>> shamt);  // keeps the sign
         end
         ALU_OR: begin
            result = left_operand | right_operand;
         end
         ALU_AND: begin
            result = left_operand & right_operand;
         end
         ALU_PASS_B: begin
            result = right_operand;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

// ==== design/pipe_mult.sv ====
module pipe_mult
   import core_pkg::*, exec_pkg::*;
(
   input  logic   clk,
   input  logic   arst_n,
   input  logic   issue,
   input  word_t  mcand,
   input  word_t  mplier,
   input  robid_t issue_robid,
   input  prd_t   issue_prd,
   input  logic   flush_valid,
   input  robid_t flush_robid,
   output logic   out_valid,
   output robid_t out_robid,
   output prd_t   out_prd,
   output word_t  product
);

   // tags travel alongside the data, one slot per stage
   logic [MUL_LATENCY-1:0] valid_q;
   robid_t                 robid_q [MUL_LATENCY];
   prd_t                   prd_q   [MUL_LATENCY];

   half_t a_lo;
   half_t a_hi;
   half_t b_lo;
   half_t b_hi;

   word_t pp_ll;
   half_t pp_lh;
   half_t pp_hl;

   // stage 1
   word_t pp_ll_q;
   half_t pp_lh_q;
   half_t pp_hl_q;

   // stage 2
   word_t ll_q;
   half_t cross_q;

   // stage 3
   word_t product_q;

   assign a_lo = mcand[HALF_WIDTH-1:0];
   assign a_hi = mcand[XLEN-1:HALF_WIDTH];
   assign b_lo = mplier[HALF_WIDTH-1:0];
   assign b_hi = mplier[XLEN-1:HALF_WIDTH];

   // low 32 bits are the same for signed and unsigned operands,
   // so hi*hi drops out and the cross terms only need 16 bits
   always_comb begin
      pp_ll = word_t'(a_lo) * word_t'(b_lo);
      pp_lh = a_lo * b_hi;
      pp_hl = a_hi * b_lo;
   end

   always_ff @(posedge clk) begin
      pp_ll_q   <= pp_ll;
      pp_lh_q   <= pp_lh;
      pp_hl_q   <= pp_hl;
      ll_q      <= pp_ll_q;
      cross_q   <= pp_lh_q + pp_hl_q;
      product_q <= ll_q + {cross_q, {HALF_WIDTH{1'b0}}};
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= '0;
      end else begin
         valid_q[0] <= issue & ~flush_valid;  // flush cycle issue is dropped
         for (int i = 1; i < MUL_LATENCY; i++) begin
            valid_q[i] <= valid_q[i-1] &
                          ~(flush_valid & rob_younger(robid_q[i-1], flush_robid));
         end
      end
   end

   always_ff @(posedge clk) begin
      robid_q[0] <= issue_robid;
      prd_q[0]   <= issue_prd;
      for (int i = 1; i < MUL_LATENCY; i++) begin
         robid_q[i] <= robid_q[i-1];
         prd_q[i]   <= prd_q[i-1];
      end
   end

   assign out_valid = valid_q[MUL_LATENCY-1];
   assign out_robid = robid_q[MUL_LATENCY-1];
   assign out_prd   = prd_q[MUL_LATENCY-1];
   assign product   = product_q;

endmodule

// ==== design/int0_mul_alu.sv ====
module int0_mul_alu
   import core_pkg::*, exec_pkg::*;
(
   input  logic    clk,
   input  logic    arst_n,

   input  logic    int0_valid,
   input  word_t   int0_pc,
   input  word_t   int0_rs1,
   input  word_t   int0_rs2,
   input  word_t   int0_imm,
   input  alu_op_t int0_alu_op,
   input  logic    int0_is_auipc,
   input  logic    int0_alu_src,
   input  logic    int0_reg_write,
   input  logic    int0_is_mul,
   input  prd_t    int0_prd,
   input  robid_t  int0_robid,

   input  logic    flush_valid,
   input  robid_t  flush_robid,

   // writeback0, multiplier
   output logic    wb0_valid,
   output prd_t    wb0_prd,
   output robid_t  wb0_robid,
   output word_t   wb0_data,

   // writeback1, alu
   output logic    wb1_valid,
   output logic    wb1_need_wb,
   output prd_t    wb1_prd,
   output robid_t  wb1_robid,
   output word_t   wb1_data
);

   word_t left_operand;
   word_t right_operand;
   logic  mul_issue;

   always_comb begin
      left_operand  = int0_is_auipc ? int0_pc : int0_rs1;
      right_operand = int0_rs2;
      if (int0_alu_src) begin
         right_operand = int0_imm;
      end
   end

   alu i_alu (
      .alu_op        (int0_alu_op),
      .left_operand  (left_operand),
      .right_operand (right_operand),
      .result        (wb1_data)
   );

   // same cycle writeback, dropped on flush
   assign wb1_valid   = int0_valid & ~int0_is_mul & ~flush_valid;
   assign wb1_need_wb = int0_reg_write;
   assign wb1_prd     = int0_prd;
   assign wb1_robid   = int0_robid;

   assign mul_issue = int0_valid & int0_is_mul;

   // squash decision lives inside the pipeline
   pipe_mult i_pipe_mult (
      .clk         (clk),
      .arst_n      (arst_n),
      .issue       (mul_issue),
      .mcand       (left_operand),
      .mplier      (right_operand),
      .issue_robid (int0_robid),
      .issue_prd   (int0_prd),
      .flush_valid (flush_valid),
      .flush_robid (flush_robid),
      .out_valid   (wb0_valid),
      .out_robid   (wb0_robid),
      .out_prd     (wb0_prd),
      .product     (wb0_data)
   );

endmodule

// ==== verification/int0_mul_alu_tb.sv ====
module int0_mul_alu_tb
   import core_pkg::*, exec_pkg::*;
();

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 10;
   localparam int MAX_VECTORS  = 256;
   localparam int STIM_FIELDS  = 23;

   logic    clk;
   logic    arst_n;
   logic    int0_valid;
   word_t   int0_pc;
   word_t   int0_rs1;
   word_t   int0_rs2;
   word_t   int0_imm;
   alu_op_t int0_alu_op;
   logic    int0_is_auipc;
   logic    int0_alu_src;
   logic    int0_reg_write;
   logic    int0_is_mul;
   prd_t    int0_prd;
   robid_t  int0_robid;
   logic    flush_valid;
   robid_t  flush_robid;

   logic    wb0_valid;
   prd_t    wb0_prd;
   robid_t  wb0_robid;
   word_t   wb0_data;
   logic    wb1_valid;
   logic    wb1_need_wb;
   prd_t    wb1_prd;
   robid_t  wb1_robid;
   word_t   wb1_data;

   // input columns of the stimulus file
   logic       vec_valid       [MAX_VECTORS];
   word_t      vec_pc          [MAX_VECTORS];
   word_t      vec_rs1         [MAX_VECTORS];
   word_t      vec_rs2         [MAX_VECTORS];
   word_t      vec_imm         [MAX_VECTORS];
   logic [3:0] vec_op          [MAX_VECTORS];
   logic       vec_auipc       [MAX_VECTORS];
   logic       vec_src         [MAX_VECTORS];
   logic       vec_regw        [MAX_VECTORS];
   logic       vec_mul         [MAX_VECTORS];
   prd_t       vec_prd         [MAX_VECTORS];
   robid_t     vec_robid       [MAX_VECTORS];
   logic       vec_flush       [MAX_VECTORS];
   robid_t     vec_flush_robid [MAX_VECTORS];

   // expected columns
   logic   exp_wb1_valid [MAX_VECTORS];
   logic   exp_wb1_need  [MAX_VECTORS];
   prd_t   exp_wb1_prd   [MAX_VECTORS];
   robid_t exp_wb1_robid [MAX_VECTORS];
   word_t  exp_wb1_data  [MAX_VECTORS];
   logic   exp_wb0_valid [MAX_VECTORS];
   prd_t   exp_wb0_prd   [MAX_VECTORS];
   robid_t exp_wb0_robid [MAX_VECTORS];
   word_t  exp_wb0_data  [MAX_VECTORS];

   int   vec_count;
   logic vectors_loaded;

   // muls in flight, in issue order
   int     mq_due   [$];
   robid_t mq_robid [$];
   prd_t   mq_prd   [$];
   logic   model_valid;
   robid_t model_robid;
   prd_t   model_prd;

   int0_mul_alu i_dut (
      .clk            (clk),
      .arst_n         (arst_n),
      .int0_valid     (int0_valid),
      .int0_pc        (int0_pc),
      .int0_rs1       (int0_rs1),
      .int0_rs2       (int0_rs2),
      .int0_imm       (int0_imm),
      .int0_alu_op    (int0_alu_op),
      .int0_is_auipc  (int0_is_auipc),
      .int0_alu_src   (int0_alu_src),
      .int0_reg_write (int0_reg_write),
      .int0_is_mul    (int0_is_mul),
      .int0_prd       (int0_prd),
      .int0_robid     (int0_robid),
      .flush_valid    (flush_valid),
      .flush_robid    (flush_robid),
      .wb0_valid      (wb0_valid),
      .wb0_prd        (wb0_prd),
      .wb0_robid      (wb0_robid),
      .wb0_data       (wb0_data),
      .wb1_valid      (wb1_valid),
      .wb1_need_wb    (wb1_need_wb),
      .wb1_prd        (wb1_prd),
      .wb1_robid      (wb1_robid),
      .wb1_data       (wb1_data)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("CHECKS FAILED");
      $fatal(1, "run stopped");
   endtask

   task automatic check_bit(input string field, input logic got, input logic expected);
      if (got !== expected) begin
         stop_with_failure($sformatf("FAIL at time %0t: %s expected %b got %b",
                                     $time, field, expected, got));
      end
   endtask

   task automatic check_word(input string field, input word_t got, input word_t expected);
      if (got !== expected) begin
         stop_with_failure($sformatf("FAIL at time %0t: %s expected %h got %h",
                                     $time, field, expected, got));
      end
   endtask

   task automatic check_robid(input string field, input robid_t got, input robid_t expected);
      if (got !== expected) begin
         stop_with_failure($sformatf("FAIL at time %0t: %s expected %h got %h",
                                     $time, field, expected, got));
      end
   endtask

   task automatic check_prd(input string field, input prd_t got, input prd_t expected);
      if (got !== expected) begin
         stop_with_failure($sformatf("FAIL at time %0t: %s expected %h got %h",
                                     $time, field, expected, got));
      end
   endtask

   task automatic load_vectors();
      int          fd;
      int          rc;
      int          cnt;
      int          line_no;
      string       line;
      logic [31:0] f [STIM_FIELDS];
      fd = $fopen("verification/int0_stim.txt", "r");
      if (fd == 0) begin
         stop_with_failure("could not open the stimulus file verification/int0_stim.txt");
      end
      vec_count = 0;
      line_no   = 0;
      while (!$feof(fd)) begin
         rc = $fgets(line, fd);
         line_no++;
         if (rc > 1 && line.getc(0) != "#") begin  // skip blank and comment lines
            cnt = $sscanf(line,
               "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
               f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
               f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22]);
            if (cnt != STIM_FIELDS) begin
               stop_with_failure($sformatf("stimulus line %0d is malformed", line_no));
            end
            if (vec_count >= MAX_VECTORS) begin
               stop_with_failure("the stimulus file holds more vectors than the testbench");
            end
            vec_valid[vec_count]       = f[0][0];
            vec_pc[vec_count]          = f[1];
            vec_rs1[vec_count]         = f[2];
            vec_rs2[vec_count]         = f[3];
            vec_imm[vec_count]         = f[4];
            vec_op[vec_count]          = f[5][3:0];
            vec_auipc[vec_count]       = f[6][0];
            vec_src[vec_count]         = f[7][0];
            vec_regw[vec_count]        = f[8][0];
            vec_mul[vec_count]         = f[9][0];
            vec_prd[vec_count]         = prd_t'(f[10]);
            vec_robid[vec_count]       = robid_t'(f[11]);
            vec_flush[vec_count]       = f[12][0];
            vec_flush_robid[vec_count] = robid_t'(f[13]);
            exp_wb1_valid[vec_count]   = f[14][0];
            exp_wb1_need[vec_count]    = f[15][0];
            exp_wb1_prd[vec_count]     = prd_t'(f[16]);
            exp_wb1_robid[vec_count]   = robid_t'(f[17]);
            exp_wb1_data[vec_count]    = f[18];
            exp_wb0_valid[vec_count]   = f[19][0];
            exp_wb0_prd[vec_count]     = prd_t'(f[20]);
            exp_wb0_robid[vec_count]   = robid_t'(f[21]);
            exp_wb0_data[vec_count]    = f[22];
            vec_count++;
         end
      end
      $fclose(fd);
      if (vec_count == 0) begin
         stop_with_failure("the stimulus file holds no vectors");
      end
   endtask

   task automatic idle_inputs();
      int0_valid     = 1'b0;
      int0_pc        = '0;
      int0_rs1       = '0;
      int0_rs2       = '0;
      int0_imm       = '0;
      int0_alu_op    = ALU_ADD;
      int0_is_auipc  = 1'b0;
      int0_alu_src   = 1'b0;
      int0_reg_write = 1'b0;
      int0_is_mul    = 1'b0;
      int0_prd       = '0;
      int0_robid     = '0;
      flush_valid    = 1'b0;
      flush_robid    = '0;
   endtask

   task automatic drive_row(input int t);
      int0_valid     = vec_valid[t];
      int0_pc        = vec_pc[t];
      int0_rs1       = vec_rs1[t];
      int0_rs2       = vec_rs2[t];
      int0_imm       = vec_imm[t];
      int0_alu_op    = alu_op_t'(vec_op[t]);
      int0_is_auipc  = vec_auipc[t];
      int0_alu_src   = vec_src[t];
      int0_reg_write = vec_regw[t];
      int0_is_mul    = vec_mul[t];
      int0_prd       = vec_prd[t];
      int0_robid     = vec_robid[t];
      flush_valid    = vec_flush[t];
      flush_robid    = vec_flush_robid[t];
   endtask

   // wb0 expectation for row t, then flush and issue of that row
   task automatic advance_mul_model(input int t);
      int     keep_due   [$];
      robid_t keep_robid [$];
      prd_t   keep_prd   [$];
      model_valid = 1'b0;
      model_robid = '0;
      model_prd   = '0;
      if (mq_due.size() > 0 && mq_due[0] == t) begin
         model_valid = 1'b1;
         model_robid = mq_robid.pop_front();
         model_prd   = mq_prd.pop_front();
         void'(mq_due.pop_front());
      end
      if (vec_flush[t]) begin
         foreach (mq_due[i]) begin
            if (!rob_younger(mq_robid[i], vec_flush_robid[t])) begin
               keep_due.push_back(mq_due[i]);
               keep_robid.push_back(mq_robid[i]);
               keep_prd.push_back(mq_prd[i]);
            end
         end
         mq_due   = keep_due;
         mq_robid = keep_robid;
         mq_prd   = keep_prd;
      end
      if (vec_valid[t] && vec_mul[t] && !vec_flush[t]) begin
         mq_due.push_back(t + MUL_LATENCY);
         mq_robid.push_back(vec_robid[t]);
         mq_prd.push_back(vec_prd[t]);
      end
   endtask

   task automatic check_row(input int t);
      check_bit("wb1_valid", wb1_valid, exp_wb1_valid[t]);
      if (exp_wb1_valid[t]) begin
         check_bit("wb1_need_wb", wb1_need_wb, exp_wb1_need[t]);
         check_prd("wb1_prd", wb1_prd, exp_wb1_prd[t]);
         check_robid("wb1_robid", wb1_robid, exp_wb1_robid[t]);
         check_word("wb1_data", wb1_data, exp_wb1_data[t]);
      end
      check_bit("wb0_valid", wb0_valid, exp_wb0_valid[t]);
      check_bit("wb0_valid against mul queue", wb0_valid, model_valid);
      if (exp_wb0_valid[t]) begin
         check_prd("wb0_prd", wb0_prd, exp_wb0_prd[t]);
         check_robid("wb0_robid", wb0_robid, exp_wb0_robid[t]);
         check_word("wb0_data", wb0_data, exp_wb0_data[t]);
      end
      if (model_valid) begin
         check_prd("wb0_prd against mul queue", wb0_prd, model_prd);
         check_robid("wb0_robid against mul queue", wb0_robid, model_robid);
      end
   endtask

   initial begin
      vectors_loaded = 1'b0;
      arst_n         = 1'b0;
      idle_inputs();
      load_vectors();
      vectors_loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      arst_n = 1'b1;
      for (int t = 0; t < vec_count; t++) begin
         @(posedge clk);
         #1;
         drive_row(t);
         #(CLK_PERIOD - 2);  // sample just before the next edge
         advance_mul_model(t);
         check_row(t);
      end
      @(posedge clk);
      #1;
      idle_inputs();
      $display("ALL CHECKS PASSED");
      $finish;
   end

   initial begin
      wait (vectors_loaded);
      #((vec_count + 20) * CLK_PERIOD);
      stop_with_failure("simulation timed out before all vectors were checked");
   end

endmodule

// ==== verification/int0_stim.txt ====
# v pc rs1 rs2 imm op auipc src regw mul prd robid fv frobid | wb1 v nw prd robid data | wb0 v prd robid data
# all hex; a port's fields are only checked when its expected valid is 1
1 00001000 00000005 00000007 00000000 0 0 0 1 0 01 00 0 00 1 1 01 00 0000000c 0 00 00 00000000
1 00001000 00000003 00000005 00000000 1 0 0 1 0 02 01 0 00 1 1 02 01 fffffffe 0 00 00 00000000
1 00001000 00000001 00000024 00000000 2 0 0 1 0 03 02 0 00 1 1 03 02 00000010 0 00 00 00000000
1 00001000 ffffffff 00000001 00000000 3 0 0 1 0 04 03 0 00 1 1 04 03 00000001 0 00 00 00000000
1 00001000 ffffffff 00000001 00000000 4 0 0 1 0 05 04 0 00 1 1 05 04 00000000 0 00 00 00000000
1 00001000 00000002 80000000 00000000 3 0 0 1 0 06 05 0 00 1 1 06 05 00000000 0 00 00 00000000
1 00001000 00000002 80000000 00000000 4 0 0 1 0 07 06 0 00 1 1 07 06 00000001 0 00 00 00000000
1 00001000 f0f0f0f0 0ff00ff0 00000000 5 0 0 1 0 08 07 0 00 1 1 08 07 ff00ff00 0 00 00 00000000
1 00001000 80000000 0000003f 00000000 6 0 0 1 0 09 08 0 00 1 1 09 08 00000001 0 00 00 00000000
1 00001000 80000000 00000004 00000000 7 0 0 1 0 0a 09 0 00 1 1 0a 09 f8000000 0 00 00 00000000
1 00001000 7ffffff0 00000021 00000000 7 0 0 1 0 0b 0a 0 00 1 1 0b 0a 3ffffff8 0 00 00 00000000
1 00001000 12340000 00005678 00000000 8 0 0 1 0 0c 0b 0 00 1 1 0c 0b 12345678 0 00 00 00000000
1 00001000 ff00ff00 0ff00ff0 00000000 9 0 0 1 0 0d 0c 0 00 1 1 0d 0c 0f000f00 0 00 00 00000000
1 00001000 22222222 11111111 abcde000 a 0 1 1 0 0e 0d 0 00 1 1 0e 0d abcde000 0 00 00 00000000
1 00001000 00000010 00000020 00000000 0 0 0 0 0 00 0e 0 00 1 0 00 0e 00000030 0 00 00 00000000
1 00001000 deadbeef 00000000 00002000 0 1 1 1 0 0f 0f 0 00 1 1 0f 0f 00003000 0 00 00 00000000
1 00001000 00000100 00000999 fffffff0 0 0 1 1 0 10 10 0 00 1 1 10 10 000000f0 0 00 00 00000000
1 00001000 0000000f 0000001f 00000000 2 0 0 1 0 11 11 0 00 1 1 11 11 80000000 0 00 00 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000007 00000006 00000000 0 0 0 1 1 12 12 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 fffffffd 00000005 00000000 0 0 0 1 1 13 13 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 ffffffff ffffffff 00000000 0 0 0 1 1 14 14 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00012345 00010000 00000000 0 0 0 1 1 15 15 0 00 0 0 00 00 00000000 1 12 12 0000002a
1 00001000 80000000 00000002 00000000 0 0 0 1 1 16 16 0 00 0 0 00 00 00000000 1 13 13 fffffff1
1 00001000 00000001 00000001 00000000 0 0 0 1 0 17 17 0 00 1 1 17 17 00000002 1 14 14 00000001
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 1 15 15 23450000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 1 16 16 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000003 00000004 00000000 0 0 0 1 1 18 18 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000005 00000005 00000000 0 0 0 1 1 19 19 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000009 00000009 00000000 0 0 0 1 1 1a 1a 1 18 0 0 00 00 00000000 0 00 00 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 1 18 18 0000000c
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 0 00 00 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 fffffffe fffffffe 00000000 0 0 0 1 1 1b 1b 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000002 00000003 00000000 0 0 0 1 1 1c 1d 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000001 00000002 00000000 0 0 0 1 0 1d 1e 1 1c 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000040 00000002 00000000 0 0 0 1 0 1e 1f 0 00 1 1 1e 1f 00000042 1 1b 1b 00000004
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 0 00 00 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00010001 00010001 00000000 0 0 0 1 1 20 1e 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000011 00000011 00000000 0 0 0 1 1 21 21 0 00 0 0 00 00 00000000 0 00 00 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 1 20 0 0 00 00 00000000 0 00 00 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 1 20 1e 00020001
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 0 00 00 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 ffff0000 00000010 00000000 0 0 0 1 1 22 3f 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000007 00000007 00000000 0 0 0 1 1 23 01 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000002 00000002 00000000 0 0 0 1 1 24 02 1 00 0 0 00 00 00000000 0 00 00 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 1 22 3f fff00000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 0 00 00 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000064 0000000a 00000000 0 0 0 1 1 25 03 0 00 0 0 00 00 00000000 0 00 00 00000000
1 00001000 00000064 0000000a 00000000 1 0 0 1 0 26 04 0 00 1 1 26 04 0000005a 0 00 00 00000000
1 00001000 0000ffff 00000000 000000ff 5 0 1 1 0 27 05 0 00 1 1 27 05 0000ff00 0 00 00 00000000
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 1 25 03 000003e8
0 00000000 00000000 00000000 00000000 0 0 0 0 0 00 00 0 00 0 0 00 00 00000000 0 00 00 00000000

// ==== build.f ====
design/core_pkg.sv
design/exec_pkg.sv
design/alu.sv
design/pipe_mult.sv
design/int0_mul_alu.sv
verification/int0_mul_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the int0 execute cluster testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -f "$log"

if ! verilator --binary -j 0 -f build.f --top-module int0_mul_alu_tb \
      -Mdir obj_dir -o int0_sim; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/int0_sim > "$log" 2>&1
sim_status=$?
cat "$log"

if [ "$sim_status" -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "ALL CHECKS PASSED" "$log"; then
   echo "run passed"
   exit 0
fi

echo "run failed, pass message not found in $log"
exit 1
